//--- verilog/posit_pkg.sv
/* Widths, raw posit value types and the Wishbone register map shared by the
   posit MAC datapath, its register block and the testbench */
package posit_pkg;

    localparam int POSIT_N  = 16;
    localparam int POSIT_ES = 3;
    localparam int MBITS    = 12;
    localparam int PBITS    = 24;
    localparam int ABITS    = 48;
    localparam int SCALE_W  = 10;

    // Fractions keep the hidden bit in the top position, scale is two's complement
    typedef struct packed {
        logic               sgn;
        logic [SCALE_W-1:0] scale;
        logic [MBITS-1:0]   fraction;
        logic               inf;
        logic               zero;
    } raw_posit_t;

    typedef struct packed {
        logic               sgn;
        logic [SCALE_W-1:0] scale;
        logic [PBITS-1:0]   fraction;
        logic               inf;
        logic               zero;
    } raw_prod_t;

    typedef struct packed {
        logic               sgn;
        logic [SCALE_W-1:0] scale;
        logic [ABITS-1:0]   fraction;
        logic               inf;
        logic               zero;
    } raw_accum_t;

    // Word addresses; control is write-only and status read-only at address 2
    localparam logic [1:0] REG_OPA    = 2'd0;
    localparam logic [1:0] REG_OPB    = 2'd1;
    localparam logic [1:0] REG_CTRL   = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_RESULT = 2'd3;

    localparam int CTRL_CLEAR = 0;
    localparam int CTRL_MAC   = 1;

    localparam int STAT_BUSY  = 0;
    localparam int STAT_TRUNC = 1;
    localparam int STAT_NAR   = 2;

endpackage

//--- verilog/posit_if.sv
/* Bundles between the register block, the posit datapath and the accumulator.
   mac_cmd_if carries the MAC command, accum_if the product and the running sum */
`timescale 1ns/10ps

interface mac_cmd_if;
    logic                          start;
    logic                          clear;
    logic [posit_pkg::POSIT_N-1:0] opa;
    logic [posit_pkg::POSIT_N-1:0] opb;

    modport host (output start, clear, opa, opb);
    modport core (input start, clear, opa, opb);
endinterface

interface accum_if;
    logic                  valid;
    posit_pkg::raw_prod_t  value;
    logic                  done;
    posit_pkg::raw_accum_t acc;
    logic                  truncated;

    modport src  (output valid, value);
    modport sink (input valid, value, output done, acc, truncated);
    modport mon  (input done, acc, truncated);
endinterface

//--- verilog/posit_decode.sv
/* Decodes both 16-bit posit operands into raw sign, scale and fraction form.
   Results are registered on the start pulse, with start delayed to match */
`timescale 1ns/10ps

module posit_decode (
    input  logic                  clk,
    input  logic                  rst,
    mac_cmd_if.core               cmd,
    output posit_pkg::raw_posit_t a_raw,
    output posit_pkg::raw_posit_t b_raw,
    output logic                  dec_start
);
    localparam int N  = posit_pkg::POSIT_N;
    localparam int ES = posit_pkg::POSIT_ES;
    localparam int SW = posit_pkg::SCALE_W;

    function automatic posit_pkg::raw_posit_t decode(input logic [N-1:0] p);
        posit_pkg::raw_posit_t r;
        logic [N-1:0]          mag;
        logic [N-2:0]          rem;
        logic [N-2:0]          body;
        logic [4:0]            run;
        logic                  stop;
        logic [SW-1:0]         k;
        mag = p[N-1] ? -p : p;
        rem = mag[N-2:0];
        // Regime run length, the first bit counts itself
        run = 5'd1;
        stop = 1'b0;
        for (int i = N - 3; i >= 0; i--)
        begin
            if (!stop && rem[i] == rem[N-2])
                run = run + 5'd1;
            else
                stop = 1'b1;
        end
        k = rem[N-2] ? {{(SW-5){1'b0}}, run} - 1'b1 : -{{(SW-5){1'b0}}, run};
        // Drop the regime and its terminator
        body = rem << (run + 5'd1);
        r.sgn = p[N-1];
        r.scale = {k[SW-1-ES:0], body[N-2 -: ES]};
        r.fraction = {1'b1, body[N-2-ES -: posit_pkg::MBITS-1]};
        r.zero = (p == '0);
        r.inf = (p == {1'b1, {(N-1){1'b0}}});
        if (r.zero || r.inf)
        begin
            r.sgn = 1'b0;
            r.scale = '0;
            r.fraction = '0;
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec_start <= 1'b0;
        else
            dec_start <= cmd.start;
    end

    always_ff @(posedge clk)
    begin
        if (cmd.start)
        begin
            a_raw <= decode(cmd.opa);
            b_raw <= decode(cmd.opb);
        end
    end

endmodule

//--- verilog/posit_mult_raw.sv
/* Two-stage raw multiplier. Stage one forms sign, scale sum and the fraction
   product, stage two normalizes it and presents the product on accum_if */
`timescale 1ns/10ps

module posit_mult_raw (
    input  logic                  clk,
    input  logic                  rst,
    input  posit_pkg::raw_posit_t a_raw,
    input  posit_pkg::raw_posit_t b_raw,
    input  logic                  dec_start,
    accum_if.src                  prod
);
    localparam int PB = posit_pkg::PBITS;

    logic                          s1_vld;
    logic                          s1_sgn;
    logic [posit_pkg::SCALE_W-1:0] s1_scale;
    logic [PB-1:0]                 s1_frac;
    logic                          s1_inf;
    logic                          s1_zero;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_vld <= 1'b0;
            prod.valid <= 1'b0;
        end
        else
        begin
            s1_vld <= dec_start;
            prod.valid <= s1_vld;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_sgn <= a_raw.sgn ^ b_raw.sgn;
        s1_scale <= a_raw.scale + b_raw.scale;
        s1_frac <= a_raw.fraction * b_raw.fraction;
        s1_inf <= a_raw.inf | b_raw.inf;
        s1_zero <= a_raw.zero | b_raw.zero;

        // Product of two [1,2) fractions lies in [1,4)
        prod.value.sgn <= s1_sgn;
        if (s1_frac[PB-1])
        begin
            prod.value.fraction <= s1_frac;
            prod.value.scale <= s1_scale + 1'b1;
        end
        else
        begin
            prod.value.fraction <= s1_frac << 1;
            prod.value.scale <= s1_scale;
        end
        // NaR wins over zero
        prod.value.inf <= s1_inf;
        prod.value.zero <= s1_zero & ~s1_inf;
    end

endmodule

//--- verilog/posit_accum.sv
/* Raw accumulator: compare/swap, align, add or subtract, then normalize.
   The registered sum feeds back as the next operand, a clear loads zero */
`timescale 1ns/10ps

module posit_accum (
    input  logic    clk,
    input  logic    rst,
    mac_cmd_if.core cmd,
    accum_if.sink   prod
);
    localparam int AB   = posit_pkg::ABITS;
    localparam int SW   = posit_pkg::SCALE_W;
    localparam int LZ_W = $clog2(AB + 1);

    posit_pkg::raw_accum_t acc_q;
    posit_pkg::raw_accum_t in_val;
    posit_pkg::raw_accum_t s0_hi;
    posit_pkg::raw_accum_t s0_lo;
    posit_pkg::raw_accum_t s1_hi;
    posit_pkg::raw_accum_t nxt;
    logic                  in_bigger;
    logic                  s0_vld, s1_vld, s2_vld;
    logic                  s0_add, s1_add;
    logic [SW:0]           diff;
    logic [2*AB-1:0]       lo_wide;
    logic [AB-1:0]         lo_sh, s1_lo_sh;
    logic                  lost, s1_lost, s2_lost;
    logic                  s1_lo_inf;
    logic [AB:0]           s2_sum;
    logic                  s2_sgn, s2_inf, s2_zero;
    logic [SW-1:0]         s2_scale;
    logic [LZ_W-1:0]       lz;
    logic                  found;

    assign in_val = '{prod.value.sgn, prod.value.scale,
                      {prod.value.fraction, {(AB - posit_pkg::PBITS){1'b0}}},
                      prod.value.inf, prod.value.zero};

    // Magnitude order, a zero operand always goes low
    always_comb
    begin
        if (acc_q.zero)
            in_bigger = 1'b1;
        else if (in_val.zero)
            in_bigger = 1'b0;
        else if (in_val.scale != acc_q.scale)
            in_bigger = $signed(in_val.scale) > $signed(acc_q.scale);
        else
            in_bigger = in_val.fraction >= acc_q.fraction;
    end

    // Alignment, bits shifted past the low half are lost
    always_comb
    begin
        diff = {s0_hi.scale[SW-1], s0_hi.scale} - {s0_lo.scale[SW-1], s0_lo.scale};
        lo_wide = {s0_lo.fraction, {AB{1'b0}}} >> diff;
        if (s0_lo.zero)
        begin
            lo_sh = '0;
            lost = 1'b0;
        end
        else if (diff >= 2 * AB)
        begin
            lo_sh = '0;
            lost = 1'b1;
        end
        else
        begin
            lo_sh = lo_wide[2*AB-1:AB];
            lost = |lo_wide[AB-1:0];
        end
    end

    // Leading one search and renormalization
    always_comb
    begin
        lz = '0;
        found = 1'b0;
        for (int i = AB - 1; i >= 0; i--)
        begin
            if (s2_sum[i])
                found = 1'b1;
            else if (!found)
                lz = lz + 1'b1;
        end
        nxt.sgn = s2_sgn;
        nxt.inf = s2_inf;
        nxt.zero = 1'b0;
        if (s2_sum[AB])
        begin
            nxt.fraction = s2_sum[AB:1];
            nxt.scale = s2_scale + 1'b1;
        end
        else
        begin
            nxt.fraction = s2_sum[AB-1:0] << lz;
            nxt.scale = s2_scale - {{(SW-LZ_W){1'b0}}, lz};
        end
        // Exact cancellation or two zero operands
        if (!s2_inf && (s2_zero || s2_sum == '0))
        begin
            nxt.sgn = 1'b0;
            nxt.scale = '0;
            nxt.fraction = '0;
            nxt.zero = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s0_vld <= 1'b0;
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            prod.done <= 1'b0;
            prod.truncated <= 1'b0;
            acc_q <= '{1'b0, '0, '0, 1'b0, 1'b1};
        end
        else
        begin
            s0_vld <= prod.valid;
            s1_vld <= s0_vld;
            s2_vld <= s1_vld;
            prod.done <= s2_vld;
            if (cmd.clear)
                acc_q <= '{1'b0, '0, '0, 1'b0, 1'b1};
            else if (s2_vld)
            begin
                acc_q <= nxt;
                prod.truncated <= s2_lost;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        s0_hi <= in_bigger ? in_val : acc_q;
        s0_lo <= in_bigger ? acc_q : in_val;
        s0_add <= in_val.sgn == acc_q.sgn;

        s1_hi <= s0_hi;
        s1_lo_sh <= lo_sh;
        s1_lost <= lost;
        s1_add <= s0_add;
        s1_lo_inf <= s0_lo.inf;

        // The high operand is zero only when both are
        s2_sum <= s1_add ? {1'b0, s1_hi.fraction} + {1'b0, s1_lo_sh}
                         : {1'b0, s1_hi.fraction} - {1'b0, s1_lo_sh};
        s2_sgn <= s1_hi.sgn;
        s2_scale <= s1_hi.scale;
        s2_inf <= s1_hi.inf | s1_lo_inf;
        s2_zero <= s1_hi.zero;
        s2_lost <= s1_lost;
    end

    assign prod.acc = acc_q;

endmodule

//--- verilog/posit_encode.sv
/* Combinational encoder from the raw accumulator to a 16-bit posit.
   Rounds to nearest even and saturates to maxpos or minpos */
`timescale 1ns/10ps

module posit_encode (
    input  posit_pkg::raw_accum_t acc,
    output logic [15:0]           result
);
    localparam int N         = posit_pkg::POSIT_N;
    localparam int ES        = posit_pkg::POSIT_ES;
    localparam int AB        = posit_pkg::ABITS;
    localparam int SW        = posit_pkg::SCALE_W;
    localparam int LW        = 2 + ES + AB - 1 + N;
    localparam int MAX_SCALE = (N - 2) << ES;

    logic signed [SW-1:0] scale;
    logic signed [SW-1:0] k;
    logic [SW-1:0]        amt;
    logic [LW-1:0]        body_ext;
    logic [LW-1:0]        shifted;
    logic [N-2:0]         body;
    logic                 guard;
    logic                 sticky;
    logic [N-1:0]         mag;

    always_comb
    begin
        scale = $signed(acc.scale);
        k = scale >>> ES;
        // Shortest regime is 10 or 01, the shift adds the rest of the run
        amt = k[SW-1] ? ~k : k;
        body_ext = {~k[SW-1], k[SW-1], acc.scale[ES-1:0], acc.fraction[AB-2:0],
                    {N{1'b0}}};
        if (k[SW-1])
            shifted = body_ext >> amt;
        else
            shifted = $signed(body_ext) >>> amt;
        body = shifted[LW-1 -: N-1];
        guard = shifted[LW-N];
        sticky = |shifted[LW-N-1:0];
        mag = {1'b0, body + (guard & (sticky | body[0]))};
        if (scale >= MAX_SCALE)
            mag = {1'b0, {(N-1){1'b1}}};
        else if (scale < -MAX_SCALE)
            mag = {{(N-1){1'b0}}, 1'b1};

        if (acc.inf)
            result = {1'b1, {(N-1){1'b0}}};
        else if (acc.zero)
            result = '0;
        else
            result = acc.sgn ? -mag : mag;
    end

endmodule

//--- verilog/posit_wb_regs.sv
/* Wishbone classic slave with the operand, control, status and result registers.
   A MAC write holds off its ack until the accumulator reports done */
`timescale 1ns/10ps

module posit_wb_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    input  logic [15:0] result,
    mac_cmd_if.host     cmd,
    accum_if.mon        acc_st
);
    logic        req;
    logic        ctrl_wr;
    logic        busy;
    logic        trunc_flag;
    logic        nar_flag;
    logic [31:0] status;

    // New request, not yet acknowledged
    assign req = cyc & stb & ~ack;
    assign ctrl_wr = req & we & (adr == posit_pkg::REG_CTRL);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack <= 1'b0;
            busy <= 1'b0;
            cmd.start <= 1'b0;
            cmd.clear <= 1'b0;
        end
        else
        begin
            ack <= 1'b0;
            cmd.start <= 1'b0;
            cmd.clear <= 1'b0;
            if (busy)
            begin
                if (acc_st.done)
                begin
                    busy <= 1'b0;
                    ack <= 1'b1;
                end
            end
            else if (ctrl_wr && dat_w[posit_pkg::CTRL_MAC])
            begin
                // MAC takes precedence over clear in the same write
                cmd.start <= 1'b1;
                busy <= 1'b1;
            end
            else if (req)
            begin
                ack <= 1'b1;
                cmd.clear <= ctrl_wr & dat_w[posit_pkg::CTRL_CLEAR];
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            trunc_flag <= 1'b0;
            nar_flag <= 1'b0;
        end
        else if (cmd.clear)
        begin
            trunc_flag <= 1'b0;
            nar_flag <= 1'b0;
        end
        else if (acc_st.done)
        begin
            trunc_flag <= trunc_flag | acc_st.truncated;
            nar_flag <= nar_flag | acc_st.acc.inf;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req && we && adr == posit_pkg::REG_OPA)
            cmd.opa <= dat_w[15:0];
        if (req && we && adr == posit_pkg::REG_OPB)
            cmd.opb <= dat_w[15:0];
    end

    always_comb
    begin
        status = '0;
        status[posit_pkg::STAT_BUSY] = busy;
        status[posit_pkg::STAT_TRUNC] = trunc_flag;
        status[posit_pkg::STAT_NAR] = nar_flag;
        case (adr)
            posit_pkg::REG_OPA:    dat_r = {16'b0, cmd.opa};
            posit_pkg::REG_OPB:    dat_r = {16'b0, cmd.opb};
            posit_pkg::REG_STATUS: dat_r = status;
            posit_pkg::REG_RESULT: dat_r = {16'b0, result};
            default:               dat_r = '0;
        endcase
    end

endmodule

//--- verilog/posit_mac_top.sv
/* Posit MAC unit top level with a plain Wishbone classic slave port.
   Connects the register block, decoder, multiplier, accumulator and encoder */
`timescale 1ns/10ps

module posit_mac_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);
    mac_cmd_if cmd_bus ();
    accum_if   acc_bus ();

    posit_pkg::raw_posit_t a_raw;
    posit_pkg::raw_posit_t b_raw;
    logic                  dec_start;
    logic [15:0]           result;

    posit_wb_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack),
        .result (result),
        .cmd    (cmd_bus.host),
        .acc_st (acc_bus.mon)
    );

    posit_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd_bus.core),
        .a_raw     (a_raw),
        .b_raw     (b_raw),
        .dec_start (dec_start)
    );

    posit_mult_raw u_mult (
        .clk       (clk),
        .rst       (rst),
        .a_raw     (a_raw),
        .b_raw     (b_raw),
        .dec_start (dec_start),
        .prod      (acc_bus.src)
    );

    posit_accum u_accum (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd_bus.core),
        .prod (acc_bus.sink)
    );

    posit_encode u_encode (
        .acc    (acc_bus.acc),
        .result (result)
    );

endmodule

//--- verif/posit_mac_chk.sv
/* Concurrent assertions on the Wishbone handshake and the MAC command and
   accumulator pulses, bound into posit_mac_top */
`timescale 1ns/10ps

module posit_mac_chk (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic start,
    input logic clear,
    input logic done
);
    // ack is registered, so it answers a request sampled one cycle earlier
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb))
        else $error("ack without cyc and stb");

    cmd_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(start && clear))
        else $error("start and clear high together");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done high on two consecutive cycles");

endmodule

bind posit_mac_top posit_mac_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .start (cmd_bus.start),
    .clear (cmd_bus.clear),
    .done  (acc_bus.done)
);

//--- verif/tb_posit_mac.sv
/* Directed testbench for the posit MAC unit. Drives the Wishbone port of
   posit_mac_top and checks results against power-of-two posit encodings */
`timescale 1ns/10ps

module tb_posit_mac;
    localparam int ACK_LIMIT = 50;

    logic        clk;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;

    int     errors;
    int     checks;
    int     last_wait;
    integer seed;

    posit_mac_top dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Posit of (1.frac) x 2^s, exact values only
    function automatic logic [15:0] posit_of(input int s, input logic [31:0] frac);
        logic [63:0] bits;
        int          k;
        int          pos;
        k = s >>> 3;
        bits = '0;
        pos = 63;
        if (k >= 0)
        begin
            // k+1 ones, the terminating zero is already there
            for (int i = 0; i <= k; i++)
            begin
                bits[pos] = 1'b1;
                pos--;
            end
            pos--;
        end
        else
        begin
            pos = pos + k;
            bits[pos] = 1'b1;
            pos--;
        end
        bits[pos -: 3] = s[2:0];
        bits[pos - 3 -: 32] = frac;
        return {1'b0, bits[63:49]};
    endfunction

    function automatic logic [15:0] int_posit(input int unsigned v);
        int          s;
        logic [63:0] w;
        s = 0;
        for (int i = 0; i < 32; i++)
        begin
            if (v[i])
                s = i;
        end
        // Bits below the leading one become the fraction
        w = 64'(v) << (32 - s);
        return posit_of(s, w[31:0]);
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Called on a falling edge, returns on the falling edge where ack is seen
    task automatic bus_cycle(input logic wr, input logic [1:0] a, input logic [31:0] d,
                             output logic [31:0] q);
        int n;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!ack && n < ACK_LIMIT);
        if (!ack)
        begin
            errors++;
            $display("Timeout: no ack at address %0d after %0d cycles", a, n);
        end
        q = dat_r;
        last_wait = n;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
        logic [31:0] unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic read_reg(input logic [1:0] a, output logic [31:0] q);
        bus_cycle(1'b0, a, 32'h0, q);
    endtask

    task automatic run_mac(input logic [15:0] a, input logic [15:0] b);
        write_reg(posit_pkg::REG_OPA, {16'h0, a});
        write_reg(posit_pkg::REG_OPB, {16'h0, b});
        write_reg(posit_pkg::REG_CTRL, 32'(1) << posit_pkg::CTRL_MAC);
    endtask

    task automatic clear_acc();
        write_reg(posit_pkg::REG_CTRL, 32'(1) << posit_pkg::CTRL_CLEAR);
    endtask

    task automatic expect_result(input logic [15:0] exp);
        logic [31:0] q;
        read_reg(posit_pkg::REG_RESULT, q);
        expect_eq("result", {16'h0, exp}, q);
    endtask

    task automatic expect_status(input logic [31:0] exp);
        logic [31:0] q;
        read_reg(posit_pkg::REG_STATUS, q);
        expect_eq("status", exp, q);
    endtask

    task automatic reset_state();
        expect_result(16'h0000);
        expect_status(32'h0);
    endtask

    task automatic single_product();
        clear_acc();
        run_mac(posit_of(1, 0), posit_of(1, 0));
        expect_result(posit_of(2, 0));
        run_mac(posit_of(-1, 0), posit_of(1, 0));
        expect_result(int_posit(5));
    endtask

    task automatic signed_cancel();
        logic [31:0] q;
        clear_acc();
        run_mac(posit_of(2, 0), posit_of(0, 0));
        run_mac(-posit_of(2, 0), posit_of(0, 0));
        expect_result(16'h0000);
        read_reg(posit_pkg::REG_OPA, q);
        expect_eq("opa", {16'h0, -posit_of(2, 0)}, q);
        read_reg(posit_pkg::REG_OPB, q);
        expect_eq("opb", {16'h0, posit_of(0, 0)}, q);
    endtask

    task automatic nar_sticky();
        clear_acc();
        run_mac(16'h8000, posit_of(0, 0));
        expect_result(16'h8000);
        expect_status(32'(1) << posit_pkg::STAT_NAR);
        // NaR absorbs any later product
        run_mac(posit_of(0, 0), posit_of(0, 0));
        expect_result(16'h8000);
        expect_status(32'(1) << posit_pkg::STAT_NAR);
        clear_acc();
        expect_status(32'h0);
        expect_result(16'h0000);
    endtask

    task automatic truncation();
        clear_acc();
        run_mac(posit_of(40, 0), posit_of(0, 0));
        run_mac(posit_of(-40, 0), posit_of(0, 0));
        expect_result(posit_of(40, 0));
        expect_status(32'(1) << posit_pkg::STAT_TRUNC);
    endtask

    task automatic back_pressure();
        int          sa;
        int          t;
        int unsigned sum;
        clear_acc();
        sum = 0;
        for (int i = 0; i < 6; i++)
        begin
            // Each product is 2^t with t in 0..3, so every partial sum is a small integer
            sa = $random(seed) % 6;
            t = $unsigned($random(seed)) % 4;
            sum = sum + (1 << t);
            run_mac(posit_of(sa, 0), posit_of(t - sa, 0));
            checks++;
            if (last_wait < 2)
            begin
                errors++;
                $display("MAC write %0d was acknowledged before the accumulator finished", i);
            end
        end
        expect_result(int_posit(sum));
        expect_status(32'h0);
    endtask

    initial
    begin
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = 2'd0;
        dat_w = 32'h0;
        errors = 0;
        checks = 0;
        last_wait = 0;
        seed = 32'h0f646cd3;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_state();
        single_product();
        signed_cancel();
        nar_sticky();
        truncation();
        back_pressure();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Overall run limit
    initial
    begin
        #1000000;
        $display("Simulation time limit reached before the tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

//--- all.f
verilog/posit_pkg.sv
verilog/posit_if.sv
verilog/posit_decode.sv
verilog/posit_mult_raw.sv
verilog/posit_accum.sv
verilog/posit_encode.sv
verilog/posit_wb_regs.sv
verilog/posit_mac_top.sv
verif/posit_mac_chk.sv
verif/tb_posit_mac.sv

//--- Bender.yml
package:
  name: posit_mac

sources:
  - files:
      - verilog/posit_pkg.sv
      - verilog/posit_if.sv
      - verilog/posit_decode.sv
      - verilog/posit_mult_raw.sv
      - verilog/posit_accum.sv
      - verilog/posit_encode.sv
      - verilog/posit_wb_regs.sv
      - verilog/posit_mac_top.sv
  - target: test
    files:
      - verif/posit_mac_chk.sv
      - verif/tb_posit_mac.sv
